// File: src/pong_pkg.sv
package pong_pkg;

    // Screen and sprite geometry in pixels
    localparam int h_video    = 640;   // Active pixels per line
    localparam int v_video    = 480;   // Active lines
    localparam int sq_width   = 16;    // Ball side
    localparam int pdl_width  = 12;    // Paddle thickness
    localparam int pdl_height = 96;    // Paddle height

    localparam int pdl1_x = 24;        // Left paddle column, never moves
    localparam int pdl2_x = 603;       // Right paddle column

    typedef logic [9:0] coord_t;       // Pixel coordinate
    typedef logic [3:0] score_t;
    typedef logic [6:0] hit_t;         // Offset from paddle centre

    // Home rows and columns
    localparam coord_t pdl_home_y = 10'd191;
    localparam coord_t sq_home_x  = 10'd320;   // Serve point
    localparam coord_t sq_home_y  = 10'd240;

    typedef struct packed {
        logic up;                      // Active low
        logic down;                    // Active low
    } buttons_t;

    typedef struct packed {
        coord_t x;                     // Top left corner
        coord_t y;
        logic   shown;                 // Ball visible and in play
    } ball_t;

    typedef enum logic [1:0] {
        mode_startup,
        mode_play,
        mode_over
    } game_mode_t;

    typedef enum logic [2:0] {
        coll_none,
        coll_wall_y_top,
        coll_wall_y_bottom,
        coll_miss_left,
        coll_miss_right,
        coll_pdl_face_1,               // Left paddle face
        coll_pdl_face_2,               // Right paddle face
        coll_pdl_end                   // Top or bottom end of either paddle
    } coll_kind_t;

    // Collision result, one per cycle
    typedef struct packed {
        coll_kind_t kind;
        logic       pdl_end_down;      // Ball below paddle end, or below centre on a face
        hit_t       hit;               // Face hit offset plus one
    } coll_t;

endpackage

// File: src/paddle_ctrl.sv
`timescale 1ns/1ps

module paddle_ctrl #(
    parameter int pdl_period = 62_937      // Clocks per one-pixel step
) (
    input  logic                   clk_0,
    input  logic                   rst,
    input  pong_pkg::game_mode_t   mode,
    input  pong_pkg::buttons_t     btn,
    output pong_pkg::coord_t       y       // Paddle top row
);

    localparam int cnt_w = $clog2(pdl_period + 1);

    logic [cnt_w-1:0] cnt;                 // Step prescaler
    logic             go_up;
    logic             go_down;
    logic             tick;                // Last cycle of a step period

    // Both held means no move
    assign go_up   = !btn.up && btn.down;
    assign go_down = btn.up && !btn.down;
    assign tick    = (cnt == cnt_w'(pdl_period - 1));

    always_ff @(posedge clk_0 or negedge rst) begin
        if (!rst) begin
            y   <= pong_pkg::pdl_home_y;
            cnt <= '0;
        end else if (mode != pong_pkg::mode_play) begin
            y   <= pong_pkg::pdl_home_y;   // Menu and game over park the paddle
            cnt <= '0;
        end else if (go_up || go_down) begin
            cnt <= tick ? '0 : cnt + 1'b1;
            if (tick) begin
                // Clamp at the top edge
                if (go_up && y > 0) begin
                    y <= y - 1'b1;
                end
                // Clamp with the bottom at the last line
                if (go_down && (int'(y) + pong_pkg::pdl_height < pong_pkg::v_video - 1)) begin
                    y <= y + 1'b1;
                end
            end
        end
        // Idle buttons keep the prescaler value
    end

endmodule

// File: src/ball_collide.sv
`timescale 1ns/1ps

module ball_collide (
    input  pong_pkg::ball_t  ball,
    input  pong_pkg::coord_t pdl1_y,
    input  pong_pkg::coord_t pdl2_y,
    output pong_pkg::coll_t  coll
);

    // Row check of the ball against one paddle whose column already overlaps
    function automatic pong_pkg::coll_t pdl_contact(
        input pong_pkg::ball_t      b,
        input pong_pkg::coord_t     py,
        input pong_pkg::coll_kind_t face
    );
        pong_pkg::coll_t c;
        int top;                           // Ball top row
        int bot;                           // Ball bottom row
        int pdl_top;
        int pdl_bot;
        int centre;                        // Paddle centre row
        c       = '0;
        top     = int'(b.y);
        bot     = top + pong_pkg::sq_width;
        pdl_top = int'(py);
        pdl_bot = pdl_top + pong_pkg::pdl_height;
        centre  = pdl_top + pong_pkg::pdl_height / 2;

        if (top > pdl_bot || bot < pdl_top) begin
            c.kind = pong_pkg::coll_none;  // Passes above or below
        end else if (top == pdl_bot || top == pdl_bot - 1) begin
            c.kind         = pong_pkg::coll_pdl_end;   // Ball top on paddle bottom
            c.pdl_end_down = 1'b1;
        end else if (bot == pdl_top || bot == pdl_top + 1) begin
            c.kind         = pong_pkg::coll_pdl_end;   // Ball bottom on paddle top
            c.pdl_end_down = 1'b0;
        end else begin
            c.kind = face;
            // Offset measured from the ball edge nearer the centre
            if (top >= centre) begin
                c.pdl_end_down = 1'b1;
                c.hit          = pong_pkg::hit_t'(top - centre + 1);
            end else begin
                c.pdl_end_down = 1'b0;
                c.hit          = pong_pkg::hit_t'(centre - bot + 1);
            end
        end
        return c;
    endfunction

    logic in_col_1;                        // Ball x span touches left paddle
    logic in_col_2;                        // Ball x span touches right paddle

    assign in_col_1 = (int'(ball.x) <= pong_pkg::pdl1_x + pong_pkg::pdl_width + 1) &&
                      (int'(ball.x) + pong_pkg::sq_width >= pong_pkg::pdl1_x);
    assign in_col_2 = (int'(ball.x) + pong_pkg::sq_width >= pong_pkg::pdl2_x) &&
                      (int'(ball.x) <= pong_pkg::pdl2_x + pong_pkg::pdl_width);

    always_comb begin
        coll = '0;
        // Misses first, then walls, then paddles
        if (int'(ball.x) >= pong_pkg::h_video - pong_pkg::sq_width - 1) begin
            coll.kind = pong_pkg::coll_miss_right;
        end else if (ball.x == '0) begin
            coll.kind = pong_pkg::coll_miss_left;
        end else if (int'(ball.y) >= pong_pkg::v_video - pong_pkg::sq_width - 1) begin
            coll.kind = pong_pkg::coll_wall_y_bottom;
        end else if (ball.y == '0) begin
            coll.kind = pong_pkg::coll_wall_y_top;
        end else if (in_col_1) begin
            coll = pdl_contact(ball, pdl1_y, pong_pkg::coll_pdl_face_1);
        end else if (in_col_2) begin
            coll = pdl_contact(ball, pdl2_y, pong_pkg::coll_pdl_face_2);
        end
    end

endmodule

// File: src/ball_motion.sv
`timescale 1ns/1ps

module ball_motion #(
    parameter int serve_delay   = 50_352_112,  // Hidden clocks before a serve
    parameter int ball_x_period = 125_875,     // Clocks per horizontal pixel
    parameter int ball_y_period = 125_875      // Clocks per vertical pixel
) (
    input  logic                  clk_0,
    input  logic                  rst,
    input  pong_pkg::game_mode_t  mode,
    input  pong_pkg::coll_t       coll,
    output pong_pkg::ball_t       ball,
    output pong_pkg::hit_t        hit_y,
    output logic                  miss_left,   // One-cycle pulse, point to p2
    output logic                  miss_right   // One-cycle pulse, point to p1
);

    localparam int x_cnt_w = $clog2(ball_x_period + 1);
    localparam int y_cnt_w = $clog2(ball_y_period + 1);
    localparam int srv_w   = $clog2(serve_delay + 1);

    // Ball parked at the serve point
    localparam pong_pkg::ball_t ball_home = '{
        x:     pong_pkg::sq_home_x,
        y:     pong_pkg::sq_home_y,
        shown: 1'b0
    };

    logic [x_cnt_w-1:0] x_cnt;
    logic [y_cnt_w-1:0] y_cnt;
    logic [srv_w-1:0]   serve_cnt;
    logic               serve_pending;  // Ball waits hidden at home
    logic               dir_x;          // 0 left, 1 right
    logic               dir_y;          // 0 up, 1 down
    logic               x_tick;
    logic               y_tick;
    logic               serve_done;

    assign x_tick     = (x_cnt == x_cnt_w'(ball_x_period - 1));
    assign y_tick     = (y_cnt == y_cnt_w'(ball_y_period - 1));
    assign serve_done = (serve_cnt == srv_w'(serve_delay - 1));

    always_ff @(posedge clk_0 or negedge rst) begin
        if (!rst) begin
            ball          <= ball_home;
            serve_pending <= 1'b1;
            serve_cnt     <= '0;
            x_cnt         <= '0;
            y_cnt         <= '0;
            dir_x         <= 1'b0;
            dir_y         <= 1'b0;
            hit_y         <= '0;
            miss_left     <= 1'b0;
            miss_right    <= 1'b0;
        end else begin
            miss_left  <= 1'b0;
            miss_right <= 1'b0;
            if (mode != pong_pkg::mode_play) begin
                ball          <= ball_home;
                serve_pending <= 1'b1;     // Next play starts with a serve
                serve_cnt     <= '0;
                x_cnt         <= '0;
                y_cnt         <= '0;
                hit_y         <= '0;
            end else if (serve_pending) begin
                ball <= ball_home;
                if (serve_done) begin
                    serve_pending <= 1'b0;
                    serve_cnt     <= '0;
                    ball.shown    <= 1'b1;
                    dir_x         <= 1'b0; // Serve goes left and up
                    dir_y         <= 1'b0;
                    x_cnt         <= '0;
                    y_cnt         <= '0;
                end else begin
                    serve_cnt <= serve_cnt + 1'b1;
                end
            end else begin
                x_cnt <= x_tick ? '0 : x_cnt + 1'b1;
                y_cnt <= y_tick ? '0 : y_cnt + 1'b1;
                case (coll.kind)
                    pong_pkg::coll_miss_left, pong_pkg::coll_miss_right: begin
                        miss_left     <= (coll.kind == pong_pkg::coll_miss_left);
                        miss_right    <= (coll.kind == pong_pkg::coll_miss_right);
                        ball          <= ball_home;
                        serve_pending <= 1'b1;
                    end
                    pong_pkg::coll_wall_y_bottom: begin
                        dir_y  <= 1'b0;
                        ball.y <= ball.y - 1'b1;
                    end
                    pong_pkg::coll_wall_y_top: begin
                        dir_y  <= 1'b1;
                        ball.y <= ball.y + 1'b1;
                    end
                    pong_pkg::coll_pdl_face_1, pong_pkg::coll_pdl_face_2: begin
                        dir_x  <= (coll.kind == pong_pkg::coll_pdl_face_1); // Back to the field
                        ball.x <= (coll.kind == pong_pkg::coll_pdl_face_1) ?
                                  ball.x + 1'b1 : ball.x - 1'b1;
                        dir_y  <= coll.pdl_end_down;   // Lower half sends it down
                        hit_y  <= coll.hit;
                    end
                    pong_pkg::coll_pdl_end: begin
                        dir_y  <= coll.pdl_end_down;
                        ball.y <= coll.pdl_end_down ? ball.y + 1'b1 : ball.y - 1'b1;
                        hit_y  <= pong_pkg::hit_t'(pong_pkg::pdl_height / 2);
                    end
                    default: begin
                        // Free flight
                        if (x_tick) ball.x <= dir_x ? ball.x + 1'b1 : ball.x - 1'b1;
                        if (y_tick) ball.y <= dir_y ? ball.y + 1'b1 : ball.y - 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// File: src/game_fsm.sv
`timescale 1ns/1ps

module game_fsm #(
    parameter int safe_start = 2_500_000,  // Clocks before buttons count on the menu
    parameter int max_score  = 11          // Score that ends the game
) (
    input  logic                  clk_0,
    input  logic                  rst,
    input  pong_pkg::buttons_t    btn_p1,
    input  pong_pkg::buttons_t    btn_p2,
    input  logic                  miss_left,
    input  logic                  miss_right,
    output pong_pkg::game_mode_t  mode,
    output pong_pkg::score_t      score_p1,
    output pong_pkg::score_t      score_p2
);

    localparam int safe_w = $clog2(safe_start + 1);

    logic [safe_w-1:0] safe_cnt;           // Menu safety delay
    logic              any_btn;            // Any of the four buttons pressed
    logic              safe_over;
    logic              last_point;         // Scorer is one short of max_score

    assign any_btn = !(btn_p1.up && btn_p1.down && btn_p2.up && btn_p2.down);
    assign safe_over = (safe_cnt == safe_w'(safe_start));

    // Scorer is p2 on a left miss, p1 on a right miss
    assign last_point = miss_left ?
                        (score_p2 >= pong_pkg::score_t'(max_score - 1)) :
                        (score_p1 >= pong_pkg::score_t'(max_score - 1));

    always_ff @(posedge clk_0 or negedge rst) begin
        if (!rst) begin
            mode     <= pong_pkg::mode_startup;
            safe_cnt <= '0;
            score_p1 <= '0;
            score_p2 <= '0;
        end else begin
            case (mode)
                pong_pkg::mode_startup: begin
                    if (!safe_over) begin
                        safe_cnt <= safe_cnt + 1'b1;   // Buttons ignored meanwhile
                    end else if (any_btn) begin
                        mode <= pong_pkg::mode_play;
                    end
                end
                pong_pkg::mode_play: begin
                    if (miss_left || miss_right) begin
                        if (last_point) begin
                            mode     <= pong_pkg::mode_over;
                            score_p1 <= '0;    // Fresh scores for the next game
                            score_p2 <= '0;
                        end else if (miss_left) begin
                            score_p2 <= score_p2 + 1'b1;
                        end else begin
                            score_p1 <= score_p1 + 1'b1;
                        end
                    end
                end
                pong_pkg::mode_over: begin
                    // Straight back to play, no menu
                    if (any_btn) begin
                        mode <= pong_pkg::mode_play;
                    end
                end
                default: begin
                    mode <= pong_pkg::mode_startup;
                end
            endcase
        end
    end

endmodule

// File: src/pong_top.sv
`timescale 1ns/1ps

module pong_top #(
    parameter int safe_start    = 2_500_000,   // About 0.1 s at 25.175 MHz
    parameter int serve_delay   = 50_352_112,  // About 2 s
    parameter int pdl_period    = 62_937,      // 400 px/s
    parameter int ball_x_period = 125_875,     // 200 px/s
    parameter int ball_y_period = 125_875,
    parameter int max_score     = 11
) (
    input  logic                  clk_0,
    input  logic                  rst,
    input  pong_pkg::buttons_t    btn_p1,
    input  pong_pkg::buttons_t    btn_p2,
    output pong_pkg::ball_t       ball,
    output pong_pkg::coord_t      pdl1_y,
    output pong_pkg::coord_t      pdl2_y,
    output pong_pkg::score_t      score_p1,
    output pong_pkg::score_t      score_p2,
    output pong_pkg::game_mode_t  mode,
    output pong_pkg::hit_t        hit_y
);

    pong_pkg::coll_t coll;                 // Combinational collision result
    logic            miss_left;
    logic            miss_right;

    game_fsm #(
        .safe_start (safe_start),
        .max_score  (max_score)
    ) fsm (
        .clk_0      (clk_0),
        .rst        (rst),
        .btn_p1     (btn_p1),
        .btn_p2     (btn_p2),
        .miss_left  (miss_left),
        .miss_right (miss_right),
        .mode       (mode),
        .score_p1   (score_p1),
        .score_p2   (score_p2)
    );

    // Left and right paddles
    paddle_ctrl #(.pdl_period(pdl_period)) pdl1 (
        .clk_0 (clk_0), .rst (rst), .mode (mode), .btn (btn_p1), .y (pdl1_y)
    );

    paddle_ctrl #(.pdl_period(pdl_period)) pdl2 (
        .clk_0 (clk_0), .rst (rst), .mode (mode), .btn (btn_p2), .y (pdl2_y)
    );

    ball_collide collide (
        .ball   (ball),
        .pdl1_y (pdl1_y),
        .pdl2_y (pdl2_y),
        .coll   (coll)
    );

    ball_motion #(
        .serve_delay   (serve_delay),
        .ball_x_period (ball_x_period),
        .ball_y_period (ball_y_period)
    ) motion (
        .clk_0      (clk_0),
        .rst        (rst),
        .mode       (mode),
        .coll       (coll),
        .ball       (ball),
        .hit_y      (hit_y),
        .miss_left  (miss_left),
        .miss_right (miss_right)
    );

endmodule

// File: test/tb_pong.sv
`timescale 1ns/1ps

module tb_pong;

    localparam int max_phases = 64;
    localparam int n_cols     = 13;
    localparam int margin     = 200;       // Spare cycles on top of all phase lengths

    // Columns of one phase row
    localparam int c_p1    = 0;
    localparam int c_p2    = 1;
    localparam int c_op    = 2;            // 0 for fixed cycles or a wait code
    localparam int c_len   = 3;            // Cycle count or wait limit
    localparam int c_mode  = 4;
    localparam int c_s1    = 5;
    localparam int c_s2    = 6;
    localparam int c_y1    = 7;
    localparam int c_y2    = 8;
    localparam int c_hit   = 9;
    localparam int c_bx    = 10;
    localparam int c_by    = 11;
    localparam int c_shown = 12;

    logic                 clk_0;
    logic                 rst;
    pong_pkg::buttons_t   btn_p1;
    pong_pkg::buttons_t   btn_p2;
    pong_pkg::ball_t      ball;
    pong_pkg::coord_t     pdl1_y;
    pong_pkg::coord_t     pdl2_y;
    pong_pkg::score_t     score_p1;
    pong_pkg::score_t     score_p2;
    pong_pkg::game_mode_t mode;
    pong_pkg::hit_t       hit_y;

    int ph [0:max_phases-1][0:n_cols-1];   // Phase table from the data file
    int n_phases;
    int budget;                            // Watchdog length in cycles
    int value_errors;
    int timeouts;

    // Small periods so a whole game fits in a few thousand cycles
    pong_top #(
        .safe_start    (20),
        .serve_delay   (10),
        .pdl_period    (2),
        .ball_x_period (1),
        .ball_y_period (100000),           // Ball row stays put during a rally
        .max_score     (3)
    ) uut (
        .clk_0    (clk_0),
        .rst      (rst),
        .btn_p1   (btn_p1),
        .btn_p2   (btn_p2),
        .ball     (ball),
        .pdl1_y   (pdl1_y),
        .pdl2_y   (pdl2_y),
        .score_p1 (score_p1),
        .score_p2 (score_p2),
        .mode     (mode),
        .hit_y    (hit_y)
    );

    initial begin
        clk_0 = 1'b0;
        forever #2 clk_0 = ~clk_0;         // 4 ns period
    end

    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk_0);
        $display("Watchdog expired after %0d cycles, simulation stopped", budget);
        $display("STATUS: FAIL");
        $finish;
    end

    // Step to 1 ns past the next rising edge, where inputs change and outputs are read
    task automatic next_cycle();
        @(posedge clk_0);
        #1;
    endtask

    function automatic bit event_seen(input int op, input int exp_hit, input int exp_mode);
        case (op)
            1: return ball.shown == 1'b1;
            2: return ball.shown == 1'b0;
            3: return int'(hit_y) == exp_hit;
            4: return int'(mode) == exp_mode;
            default: return 1'b1;
        endcase
    endfunction

    function automatic string event_name(input int op);
        case (op)
            1: return "serve of the ball";
            2: return "return of the ball to home";
            3: return "hit_y update";
            4: return "mode change";
            default: return "unknown event";
        endcase
    endfunction

    // Negative expected value means don't care
    task automatic compare(input string what, input int got, input int exp);
        if (exp >= 0) begin
            assert (got == exp) else begin
                $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
                value_errors++;
            end
        end
    endtask

    task automatic check_phase(input int p);
        compare($sformatf("phase %0d mode", p), int'(mode), ph[p][c_mode]);
        compare($sformatf("phase %0d score_p1", p), int'(score_p1), ph[p][c_s1]);
        compare($sformatf("phase %0d score_p2", p), int'(score_p2), ph[p][c_s2]);
        compare($sformatf("phase %0d pdl1_y", p), int'(pdl1_y), ph[p][c_y1]);
        compare($sformatf("phase %0d pdl2_y", p), int'(pdl2_y), ph[p][c_y2]);
        compare($sformatf("phase %0d hit_y", p), int'(hit_y), ph[p][c_hit]);
        compare($sformatf("phase %0d ball.x", p), int'(ball.x), ph[p][c_bx]);
        compare($sformatf("phase %0d ball.y", p), int'(ball.y), ph[p][c_by]);
        compare($sformatf("phase %0d ball.shown", p), int'(ball.shown), ph[p][c_shown]);
    endtask

    task automatic load_phases();
        int    fd;
        int    got;
        int    total;
        string line;
        int    f [0:n_cols-1];
        n_phases = 0;
        total    = 4 + margin;             // Reset cycles plus spare
        fd = $fopen("test/pong_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/pong_testdata.txt, no phases to run");
        end else begin
            while (!$feof(fd) && n_phases < max_phases) begin
                line = "";
                void'($fgets(line, fd));
                // Comment and blank lines give fewer fields
                got = $sscanf(line, "%b %b %d %d %d %d %d %d %d %d %d %d %d",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                              f[7], f[8], f[9], f[10], f[11], f[12]);
                if (got == n_cols) begin
                    for (int i = 0; i < n_cols; i++) begin
                        ph[n_phases][i] = f[i];
                    end
                    total += f[c_len];
                    n_phases++;
                end
            end
            $fclose(fd);
        end
        budget = total;                    // Starts the watchdog
    endtask

    initial begin
        int op;
        int waited;
        value_errors = 0;
        timeouts     = 0;
        rst          = 1'b0;
        btn_p1       = 2'b11;              // All released
        btn_p2       = 2'b11;
        load_phases();
        repeat (4) @(posedge clk_0);
        #1 rst = 1'b1;

        for (int p = 0; p < n_phases; p++) begin
            btn_p1 = 2'(ph[p][c_p1]);
            btn_p2 = 2'(ph[p][c_p2]);
            op     = ph[p][c_op];
            if (op == 0) begin
                repeat (ph[p][c_len]) next_cycle();
            end else begin
                waited = 0;
                while (!event_seen(op, ph[p][c_hit], ph[p][c_mode]) &&
                       waited < ph[p][c_len]) begin
                    next_cycle();
                    waited++;
                end
                assert (event_seen(op, ph[p][c_hit], ph[p][c_mode])) else begin
                    $display("Phase %0d: no %s within %0d cycles", p, event_name(op),
                             ph[p][c_len]);
                    timeouts++;
                end
            end
            check_phase(p);
        end

        $display("Done: %0d phases, %0d value errors, %0d timeouts", n_phases,
                 value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0 && n_phases > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: test/pong_testdata.txt
# p1 p2 op len | mode s1 s2 pdl1_y pdl2_y hit_y ball_x ball_y shown
# buttons {up,down} active low; op 0 cycles, 1 until shown, 2 until hidden,
# 3 until hit_y matches, 4 until mode matches; mode 0 menu 1 play 2 over; -1 don't care
11 11 0 0     0 0 0 191 191 0 320 240 0   # Reset values
01 11 0 10    0 0 0 191 191 0 320 240 0   # Press inside safety delay is ignored
11 11 0 15    0 0 0 191 191 0 320 240 0   # Delay runs out
01 11 4 5     1 0 0 191 191 0 320 240 0   # Press starts play
01 11 0 40    1 0 0 171 191 0 290 240 1   # 40 cycles up, ball served and moving left
00 11 0 10    1 0 0 171 191 0 280 240 1   # Both held, paddle stays
01 10 2 400   1 0 0 -1 -1 0 320 240 0     # Left miss, ball back home
01 10 0 1     1 0 1 -1 -1 0 320 240 0     # Point to p2
01 10 0 120   1 0 1 0 383 0 209 240 1     # Paddles clamped at both limits
10 11 0 382   1 0 2 191 383 0 158 240 1   # Second left miss while p1 goes home
11 11 3 400   1 0 2 191 383 2 38 240 1    # Face hit one row below centre
01 11 2 1000  1 0 2 0 383 2 320 240 0     # Right miss, p1 moves out of the way
11 11 0 1     1 1 2 0 383 2 320 240 0     # Point to p1
11 11 4 600   2 0 0 0 383 2 320 240 0     # Third left miss ends the game
11 11 0 2     2 0 0 191 191 0 320 240 0   # Paddles and hit_y back home
11 01 4 5     1 0 0 191 191 0 320 240 0   # Any press restarts play
11 11 1 20    1 0 0 191 191 0 320 240 1   # New serve after the delay

// File: filelist.f
src/pong_pkg.sv
src/paddle_ctrl.sv
src/ball_collide.sv
src/ball_motion.sv
src/game_fsm.sv
src/pong_top.sv
test/tb_pong.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the Pong testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_pong \
    || { echo "Build failed"; exit 1; }
out="$(./obj_dir/Vtb_pong)"
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" && echo "Run passed" || { echo "Run failed"; exit 1; }
